// ==== bench/analog_top_assertions.sv ====
/*
 * concurrent checks on analog_top, bound in from the testbench
 * sampled on adc_clk, so zero-cycle paths are seen as settled at the edge
 */

`timescale 1ns/1ps

module analog_top_assertions import rp_analog_pkg::*; (
  input logic             adc_clk,
  input logic             dp_rst_n,       // internal data-path reset
  input loop_sel_t        loop_sel_i,
  input logic             adc_dv_o,
  input code_pair_t       dac_code_o,
  input logic             trig_out_en_i,
  input logic [EXP_W-1:0] exp_n_oe_o
);

  int fail_cnt = 0;  // number of failed properties

  ////////////////////
  // data path
  ////////////////////

  // feedback stream is always valid
  adc_loop_valid: assert property (@(posedge adc_clk) loop_sel_i.adc_loop |-> adc_dv_o)
    else begin
      $error("adc_dv_o low while the ADC loop is selected");
      fail_cnt++;
    end

  // mid scale on both channels once the data path is in reset
  dac_zero_in_reset: assert property (
    @(posedge adc_clk) !dp_rst_n |=> (dac_code_o == {DAC_ZERO_CODE, DAC_ZERO_CODE})
  ) else begin
    $error("dac_code_o not at mid scale during data-path reset");
    fail_cnt++;
  end

  ////////////////////
  // expansion row
  ////////////////////

  trig_pin_drives: assert property (@(posedge adc_clk) trig_out_en_i |-> exp_n_oe_o[0])
    else begin
      $error("pin N0 not driven while the trigger output is enabled");
      fail_cnt++;
    end

endmodule

// ==== bench/analog_top_tb.sv ====
/*
 * testbench for analog_top, table driven with a reference model
 * inputs change on the rising edge, outputs are read on the falling edge
 * random rows come from $urandom with a fixed seed, stops at the first mismatch
 */

`timescale 1ns/1ps

module analog_top_tb import rp_analog_pkg::*; ();

  localparam int N_FIXED = 12;
  localparam int N_ROWS  = 18;  // fixed rows first, then random
  localparam int SAT_MAX = 2**(DAC_W-1) - 1;
  localparam int SAT_MIN = -(2**(DAC_W-1));

  // one table row, stimulus and expected saturated sums
  typedef struct packed {
    loop_sel_t        loop_sel;
    adc_pair_t        adc_raw;
    logic             adc_dv;
    dac_pair_t        asg;
    dac_pair_t        pid;
    logic [3:0]       trig;     // scope, asg, sel, en
    logic [EXP_W-1:0] exp_dat;
    logic [EXP_W-1:0] exp_dir;
    dac_pair_t        exp_sat;  // expected clamped sums
  } row_t;

  logic             adc_clk;
  logic             rst_n_i;
  logic             pll_lock_i;
  adc_pair_t        adc_raw_i;
  logic             adc_raw_dv_i;
  dac_pair_t        asg_dat_i;
  dac_pair_t        pid_dat_i;
  loop_sel_t        loop_sel_i;
  logic             trig_scope_i;
  logic             trig_asg_i;
  logic             trig_out_sel_i;
  logic             trig_out_en_i;
  logic [EXP_W-1:0] exp_n_dat_i;
  logic [EXP_W-1:0] exp_n_dir_i;
  logic             dp_rst_n_o;
  adc_pair_t        adc_dat_o;
  logic             adc_dv_o;
  code_pair_t       dac_code_o;
  logic             trig_out_o;
  logic [EXP_W-1:0] exp_n_out_o;
  logic [EXP_W-1:0] exp_n_oe_o;

  row_t  rows [N_ROWS];
  string row_name [N_ROWS];

  analog_top dut_i (
    .adc_clk        (adc_clk       ),
    .rst_n_i        (rst_n_i       ),
    .pll_lock_i     (pll_lock_i    ),
    .adc_raw_i      (adc_raw_i     ),
    .adc_raw_dv_i   (adc_raw_dv_i  ),
    .asg_dat_i      (asg_dat_i     ),
    .pid_dat_i      (pid_dat_i     ),
    .loop_sel_i     (loop_sel_i    ),
    .trig_scope_i   (trig_scope_i  ),
    .trig_asg_i     (trig_asg_i    ),
    .trig_out_sel_i (trig_out_sel_i),
    .trig_out_en_i  (trig_out_en_i ),
    .exp_n_dat_i    (exp_n_dat_i   ),
    .exp_n_dir_i    (exp_n_dir_i   ),
    .dp_rst_n_o     (dp_rst_n_o    ),
    .adc_dat_o      (adc_dat_o     ),
    .adc_dv_o       (adc_dv_o      ),
    .dac_code_o     (dac_code_o    ),
    .trig_out_o     (trig_out_o    ),
    .exp_n_out_o    (exp_n_out_o   ),
    .exp_n_oe_o     (exp_n_oe_o    )
  );

  bind analog_top analog_top_assertions asrt_i (
    .adc_clk       (adc_clk      ),
    .dp_rst_n      (dp_rst_n     ),
    .loop_sel_i    (loop_sel_i   ),
    .adc_dv_o      (adc_dv_o     ),
    .dac_code_o    (dac_code_o   ),
    .trig_out_en_i (trig_out_en_i),
    .exp_n_oe_o    (exp_n_oe_o   )
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;  // 125 MHz
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic int sat_ref(input int sum);
    if (sum > SAT_MAX)
      return SAT_MAX;
    if (sum < SAT_MIN)
      return SAT_MIN;
    return sum;
  endfunction

  // keep the sign bit and flip the other bits
  function automatic logic [DAC_W-1:0] code_ref(input int s);
    logic [DAC_W-1:0] w;
    w = s[DAC_W-1:0];
    return w ^ {1'b0, {(DAC_W-1){1'b1}}};
  endfunction

  function automatic row_t make_row(
    input loop_sel_t        ls,
    input int               adc_a, adc_b,
    input logic             dv,
    input int               asg_a, asg_b, pid_a, pid_b,
    input int               sat_a, sat_b,
    input logic [3:0]       trig,
    input logic [EXP_W-1:0] dat, dir
  );
    row_t r;
    r.loop_sel    = ls;
    r.adc_raw.cha = adc_a[ADC_W-1:0];
    r.adc_raw.chb = adc_b[ADC_W-1:0];
    r.adc_dv      = dv;
    r.asg.cha     = asg_a[DAC_W-1:0];
    r.asg.chb     = asg_b[DAC_W-1:0];
    r.pid.cha     = pid_a[DAC_W-1:0];
    r.pid.chb     = pid_b[DAC_W-1:0];
    r.exp_sat.cha = sat_a[DAC_W-1:0];
    r.exp_sat.chb = sat_b[DAC_W-1:0];
    r.trig        = trig;
    r.exp_dat     = dat;
    r.exp_dir     = dir;
    return r;
  endfunction

  task automatic build_table();
    int asg_a;
    int asg_b;
    int pid_a;
    int pid_b;
    int raw_a;
    int raw_b;
    row_name[0]  = "sum_in_range";
    rows[0]  = make_row(2'b00, 1000, -1000, 1'b1, 100, -200, 50, 30, 150, -170,
                        4'b0000, 8'h00, 8'h00);
    row_name[1]  = "sat_pos";
    rows[1]  = make_row(2'b00, 0, 0, 1'b0, 8000, 8191, 500, 8191, 8191, 8191,
                        4'b0000, 8'h00, 8'h00);
    row_name[2]  = "sat_neg";
    rows[2]  = make_row(2'b00, -5, 5, 1'b1, -8000, -8192, -500, -8192, -8192, -8192,
                        4'b0000, 8'h00, 8'h00);
    row_name[3]  = "zero";
    rows[3]  = make_row(2'b00, 0, 0, 1'b0, 0, 0, 0, 0, 0, 0, 4'b0000, 8'h00, 8'h00);
    row_name[4]  = "adc_loop";
    rows[4]  = make_row(2'b10, 300, -300, 1'b0, 1000, -1, -3000, 0, -2000, -1,
                        4'b0000, 8'h00, 8'h00);
    row_name[5]  = "adc_loop_sat";
    rows[5]  = make_row(2'b10, 7, 7, 1'b0, 7000, -7000, 2000, -2000, 8191, -8192,
                        4'b0000, 8'h00, 8'h00);
    row_name[6]  = "dac_loop";
    rows[6]  = make_row(2'b01, 32764, -32765, 1'b1, 5, 5, 1, 1, 6, 6,
                        4'b0000, 8'h00, 8'h00);
    row_name[7]  = "both_loops";
    rows[7]  = make_row(2'b11, 1234, -4321, 1'b0, -100, 200, -50, -50, -150, 150,
                        4'b0000, 8'h00, 8'h00);
    row_name[8]  = "trig_asg_pin0";
    rows[8]  = make_row(2'b00, 0, 0, 1'b0, 1, 2, 3, 4, 4, 6, 4'b0111, 8'hA4, 8'h0F);
    row_name[9]  = "trig_scope_pin0";
    rows[9]  = make_row(2'b00, 0, 0, 1'b0, 0, 0, 0, 0, 0, 0, 4'b1001, 8'hFF, 8'h00);
    row_name[10] = "trig_no_override";
    rows[10] = make_row(2'b00, 0, 0, 1'b0, 0, 0, 0, 0, 0, 0, 4'b0110, 8'h5A, 8'h3C);
    row_name[11] = "trig_low_pin0";
    rows[11] = make_row(2'b00, 0, 0, 1'b0, 0, 0, 0, 0, 0, 0, 4'b1011, 8'hFF, 8'h00);
    // random rows, expected sums from the model
    for (int i = N_FIXED; i < N_ROWS; i++) begin
      asg_a = int'($urandom_range(16383)) - 8192;
      asg_b = int'($urandom_range(16383)) - 8192;
      pid_a = int'($urandom_range(16383)) - 8192;
      pid_b = int'($urandom_range(16383)) - 8192;
      raw_a = int'($urandom_range(65535)) - 32768;
      raw_b = int'($urandom_range(65535)) - 32768;
      row_name[i] = $sformatf("random_%0d", i);
      rows[i] = make_row(2'($urandom_range(3)), raw_a, raw_b, 1'($urandom_range(1)),
                         asg_a, asg_b, pid_a, pid_b,
                         sat_ref(asg_a + pid_a), sat_ref(asg_b + pid_b),
                         4'($urandom_range(15)), 8'($urandom_range(255)),
                         8'($urandom_range(255)));
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_with_error($sformatf("Error: %s %s expected 0x%h actual 0x%h",
                                     test, what, exp, act));
  endtask

  // lock edge, then count the low cycles of the data-path reset
  task automatic check_lock_sequence(input string name);
    int waited;
    int low_cycles;
    @(posedge adc_clk);
    pll_lock_i <= 1'b1;
    waited = 0;
    @(negedge adc_clk);
    while (dp_rst_n_o !== 1'b0) begin
      waited++;
      if (waited >= 3)
        stop_with_error($sformatf("%s: dp_rst_n_o did not go low after lock", name));
      @(negedge adc_clk);
    end
    low_cycles = 0;
    while (dp_rst_n_o === 1'b0) begin
      low_cycles++;
      if (low_cycles > RST_MAX + 4)
        stop_with_error($sformatf("%s: dp_rst_n_o stuck low", name));
      @(negedge adc_clk);
    end
    check_value(name, "reset low cycles", 32'(RST_MAX), 32'(low_cycles));
  endtask

  task automatic apply_row(input row_t r);
    @(posedge adc_clk);
    loop_sel_i   <= r.loop_sel;
    adc_raw_i    <= r.adc_raw;
    adc_raw_dv_i <= r.adc_dv;
    asg_dat_i    <= r.asg;
    pid_dat_i    <= r.pid;
    {trig_scope_i, trig_asg_i, trig_out_sel_i, trig_out_en_i} <= r.trig;
    exp_n_dat_i  <= r.exp_dat;
    exp_n_dir_i  <= r.exp_dir;
  endtask

  // zero-cycle paths, read while the row is still applied
  task automatic check_comb(input int idx);
    row_t             r;
    adc_pair_t        adc_exp;
    logic             dv_exp;
    logic             trig_exp;
    logic [EXP_W-1:0] out_exp;
    logic [EXP_W-1:0] oe_exp;
    r = rows[idx];
    if (r.loop_sel.adc_loop) begin
      adc_exp.cha = 16'(int'($signed(r.exp_sat.cha)) * 4);
      adc_exp.chb = 16'(int'($signed(r.exp_sat.chb)) * 4);
      dv_exp      = 1'b1;
    end else begin
      adc_exp = r.adc_raw;
      dv_exp  = r.adc_dv;
    end
    trig_exp = r.trig[1] ? r.trig[2] : r.trig[3];
    out_exp  = r.exp_dat;
    oe_exp   = r.exp_dir;
    if (r.trig[0]) begin
      out_exp[0] = trig_exp;  // pin N0 taken over
      oe_exp[0]  = 1'b1;
    end
    check_value(row_name[idx], "adc_dat_o", 32'(adc_exp), 32'(adc_dat_o));
    check_value(row_name[idx], "adc_dv_o", 32'(dv_exp), 32'(adc_dv_o));
    check_value(row_name[idx], "trig_out_o", 32'(trig_exp), 32'(trig_out_o));
    check_value(row_name[idx], "exp_n_out_o", 32'(out_exp), 32'(exp_n_out_o));
    check_value(row_name[idx], "exp_n_oe_o", 32'(oe_exp), 32'(exp_n_oe_o));
  endtask

  // registered DAC code, one cycle after the row
  task automatic check_code(input int idx);
    row_t       r;
    code_pair_t code_exp;
    r = rows[idx];
    if (r.loop_sel.dac_loop) begin
      code_exp.cha = 14'(int'($signed(r.adc_raw.cha)) >>> ADC_SHIFT);  // top bits
      code_exp.chb = 14'(int'($signed(r.adc_raw.chb)) >>> ADC_SHIFT);
    end else begin
      code_exp.cha = code_ref(int'($signed(r.exp_sat.cha)));
      code_exp.chb = code_ref(int'($signed(r.exp_sat.chb)));
    end
    check_value(row_name[idx], "dac_code_o", 32'(code_exp), 32'(dac_code_o));
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    void'($urandom(443));
    rst_n_i        = 1'b0;
    pll_lock_i     = 1'b0;
    adc_raw_i      = '0;
    adc_raw_dv_i   = 1'b0;
    asg_dat_i.cha  = 14'sd1000;  // nonzero sum until the table starts
    asg_dat_i.chb  = -14'sd1000;
    pid_dat_i      = '0;
    loop_sel_i     = '0;
    trig_scope_i   = 1'b0;
    trig_asg_i     = 1'b0;
    trig_out_sel_i = 1'b0;
    trig_out_en_i  = 1'b0;
    exp_n_dat_i    = '0;
    exp_n_dir_i    = '0;
    build_table();

    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("reset", "dp_rst_n_o", 32'd0, 32'(dp_rst_n_o));
    check_value("reset", "dac_code_o", 32'({code_ref(0), code_ref(0)}), 32'(dac_code_o));
    @(posedge adc_clk);
    rst_n_i <= 1'b1;  // fifth edge ends reset

    check_lock_sequence("lock_first");
    @(posedge adc_clk);
    pll_lock_i <= 1'b0;  // lock lost
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("lock_lost", "dp_rst_n_o", 32'd1, 32'(dp_rst_n_o));
    check_lock_sequence("lock_again");

    for (int i = 0; i < N_ROWS; i++) begin
      apply_row(rows[i]);
      @(negedge adc_clk);
      check_comb(i);
      @(posedge adc_clk);  // code register loads
      @(negedge adc_clk);
      check_code(i);
    end

    if (dut_i.asrt_i.fail_cnt != 0) begin
      stop_with_error($sformatf("concurrent assertions failed %0d times",
                                dut_i.asrt_i.fail_cnt));
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== hdl/adc_stream_sel.sv ====
/*
 * ADC stream selector, purely combinational
 * in ADC loop the DAC samples come back scaled by 4 and valid is forced high
 */

`timescale 1ns/1ps

module adc_stream_sel import rp_analog_pkg::*; (
  input  adc_pair_t adc_raw_i,     // deserialized ADC samples
  input  logic      adc_raw_dv_i,  // raw sample strobe
  input  dac_pair_t dac_sat_i,     // saturated DAC sums
  input  logic      adc_loop_i,    // 1 selects DAC feedback
  output adc_pair_t adc_dat_o,
  output logic      adc_dv_o
);

  // DAC sample to ADC scale, low bits filled with zeros
  function automatic logic signed [ADC_W-1:0] dac_to_adc(
    input logic signed [DAC_W-1:0] dac
  );
    dac_to_adc = {dac, {ADC_SHIFT{1'b0}}};  // sign kept, times 4
  endfunction

  ////////////////////
  // stream select
  ////////////////////

  always_comb begin
    if (adc_loop_i) begin
      adc_dat_o.cha = dac_to_adc(dac_sat_i.cha);
      adc_dat_o.chb = dac_to_adc(dac_sat_i.chb);
      adc_dv_o      = 1'b1;  // feedback is always valid
    end else begin
      adc_dat_o     = adc_raw_i;
      adc_dv_o      = adc_raw_dv_i;
    end
  end

endmodule

// ==== hdl/analog_top.sv ====
/*
 * analog glue top level, single clock adc_clk
 * rst_n_i only feeds the lock sequencer, the data path runs on its reset
 * DAC channel A leaves on port A, no cross wiring
 */

`timescale 1ns/1ps

module analog_top import rp_analog_pkg::*; (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic             pll_lock_i,
  // ADC
  input  adc_pair_t        adc_raw_i,
  input  logic             adc_raw_dv_i,
  // generator and controller
  input  dac_pair_t        asg_dat_i,
  input  dac_pair_t        pid_dat_i,
  input  loop_sel_t        loop_sel_i,
  // triggers and expansion row
  input  logic             trig_scope_i,
  input  logic             trig_asg_i,
  input  logic             trig_out_sel_i,
  input  logic             trig_out_en_i,
  input  logic [EXP_W-1:0] exp_n_dat_i,
  input  logic [EXP_W-1:0] exp_n_dir_i,
  // outputs
  output logic             dp_rst_n_o,
  output adc_pair_t        adc_dat_o,
  output logic             adc_dv_o,
  output code_pair_t       dac_code_o,
  output logic             trig_out_o,
  output logic [EXP_W-1:0] exp_n_out_o,
  output logic [EXP_W-1:0] exp_n_oe_o
);

  logic      dp_rst_n;  // data-path reset
  dac_pair_t dac_sat;   // saturated sums, fed back in ADC loop

  assign dp_rst_n_o = dp_rst_n;

  ////////////////////
  // reset and data path
  ////////////////////

  lock_reset_gen i_rst_gen (
    .adc_clk    (adc_clk   ),
    .rst_n_i    (rst_n_i   ),
    .pll_lock_i (pll_lock_i),
    .dp_rst_n_o (dp_rst_n  )
  );

  adc_stream_sel i_adc_sel (
    .adc_raw_i    (adc_raw_i          ),
    .adc_raw_dv_i (adc_raw_dv_i       ),
    .dac_sat_i    (dac_sat            ),
    .adc_loop_i   (loop_sel_i.adc_loop),
    .adc_dat_o    (adc_dat_o          ),
    .adc_dv_o     (adc_dv_o           )
  );

  dac_output_stage i_dac_out (
    .adc_clk    (adc_clk            ),
    .dp_rst_n_i (dp_rst_n           ),
    .asg_dat_i  (asg_dat_i          ),
    .pid_dat_i  (pid_dat_i          ),
    .adc_raw_i  (adc_raw_i          ),
    .dac_loop_i (loop_sel_i.dac_loop),
    .dac_sat_o  (dac_sat            ),
    .dac_code_o (dac_code_o         )
  );

  // expansion row, no reset needed
  exp_pin_mux i_exp_mux (
    .trig_scope_i   (trig_scope_i  ),
    .trig_asg_i     (trig_asg_i    ),
    .trig_out_sel_i (trig_out_sel_i),
    .trig_out_en_i  (trig_out_en_i ),
    .exp_n_dat_i    (exp_n_dat_i   ),
    .exp_n_dir_i    (exp_n_dir_i   ),
    .trig_out_o     (trig_out_o    ),
    .exp_n_out_o    (exp_n_out_o   ),
    .exp_n_oe_o     (exp_n_oe_o    )
  );

endmodule

// ==== hdl/dac_output_stage.sv ====
/*
 * DAC output stage for both channels
 * generator plus controller sum, saturated to 14 bits
 * code is offset binary with negative slope, one register stage
 * DAC loop sends the top 14 raw ADC bits unconverted
 */

`timescale 1ns/1ps

module dac_output_stage import rp_analog_pkg::*; (
  input  logic       adc_clk,
  input  logic       dp_rst_n_i,  // data-path reset, active low
  input  dac_pair_t  asg_dat_i,   // generator samples
  input  dac_pair_t  pid_dat_i,   // controller samples
  input  adc_pair_t  adc_raw_i,   // raw ADC samples for DAC loop
  input  logic       dac_loop_i,  // 1 bypasses the sum
  output dac_pair_t  dac_sat_o,   // saturated sums, combinational
  output code_pair_t dac_code_o   // registered converter codes
);

  code_pair_t code_nxt;

  // add two samples, clamp to the 14 bit range
  function automatic logic signed [DAC_W-1:0] sat_sum(
    input logic signed [DAC_W-1:0] a,
    input logic signed [DAC_W-1:0] b
  );
    logic signed [DAC_W:0] sum;  // one guard bit
    sum = a + b;
    if (sum[DAC_W] ^ sum[DAC_W-1])  // overflow, top bits differ
      sat_sum = {sum[DAC_W], {(DAC_W-1){~sum[DAC_W]}}};
    else
      sat_sum = sum[DAC_W-1:0];
  endfunction

  // two's complement to offset binary, negative slope
  function automatic logic [DAC_W-1:0] to_code(
    input logic signed [DAC_W-1:0] s
  );
    to_code = {s[DAC_W-1], ~s[DAC_W-2:0]};  // sign kept, rest inverted
  endfunction

  ////////////////////
  // sum and saturation
  ////////////////////

  assign dac_sat_o.cha = sat_sum(asg_dat_i.cha, pid_dat_i.cha);
  assign dac_sat_o.chb = sat_sum(asg_dat_i.chb, pid_dat_i.chb);

  // code or raw ADC loopback
  always_comb begin
    if (dac_loop_i) begin
      code_nxt.cha = adc_raw_i.cha[ADC_W-1 -: DAC_W];  // no conversion
      code_nxt.chb = adc_raw_i.chb[ADC_W-1 -: DAC_W];
    end else begin
      code_nxt.cha = to_code(dac_sat_o.cha);
      code_nxt.chb = to_code(dac_sat_o.chb);
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge adc_clk or negedge dp_rst_n_i) begin
    if (!dp_rst_n_i) begin
      dac_code_o.cha <= DAC_ZERO_CODE;  // mid scale while in reset
      dac_code_o.chb <= DAC_ZERO_CODE;
    end else begin
      dac_code_o <= code_nxt;
    end
  end

endmodule

// ==== hdl/exp_pin_mux.sv ====
/*
 * trigger output on the N row of the expansion connector
 * only pin 0 has an alternate function, combinational
 */

`timescale 1ns/1ps

module exp_pin_mux import rp_analog_pkg::*; (
  input  logic             trig_scope_i,    // scope trigger pulse
  input  logic             trig_asg_i,      // generator trigger pulse
  input  logic             trig_out_sel_i,  // 1 selects the generator trigger
  input  logic             trig_out_en_i,   // 1 takes over pin 0
  input  logic [EXP_W-1:0] exp_n_dat_i,     // housekeeping value
  input  logic [EXP_W-1:0] exp_n_dir_i,     // housekeeping dir, 1 = output
  output logic             trig_out_o,
  output logic [EXP_W-1:0] exp_n_out_o,
  output logic [EXP_W-1:0] exp_n_oe_o
);

  assign trig_out_o = trig_out_sel_i ? trig_asg_i : trig_scope_i;

  ////////////////////
  // alternate function
  ////////////////////

  // upper pins always follow housekeeping
  assign exp_n_out_o = {exp_n_dat_i[EXP_W-1:1],
                        trig_out_en_i ? trig_out_o : exp_n_dat_i[0]};  // pin 0 carries trigger
  assign exp_n_oe_o  = {exp_n_dir_i[EXP_W-1:1],
                        trig_out_en_i | exp_n_dir_i[0]};  // trigger pin always drives

endmodule

// ==== hdl/lock_reset_gen.sv ====
/*
 * data-path reset after PLL lock
 * pll_lock_i is taken as already synchronous to adc_clk
 * losing lock aborts a running sequence, the next lock edge restarts it
 */

`timescale 1ns/1ps

module lock_reset_gen import rp_analog_pkg::*; (
  input  logic adc_clk,
  input  logic rst_n_i,     // async, active low
  input  logic pll_lock_i,  // PLL lock level
  output logic dp_rst_n_o   // data-path reset, active low, registered
);

  logic                 lock_q;   // lock, one cycle old
  logic                 lock_rise;
  logic [RST_CNT_W-1:0] rst_cnt;  // nonzero while the sequence runs

  assign lock_rise = pll_lock_i & ~lock_q;

  ////////////////////
  // lock edge and counter
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;  // so a lock already high counts as an edge
      rst_cnt <= '0;
    end else begin
      lock_q <= pll_lock_i;
      if (!pll_lock_i) begin
        rst_cnt <= '0;  // lock lost, sequence aborted
      end else if (lock_rise || (rst_cnt != '0)) begin
        if (rst_cnt < RST_CNT_W'(RST_MAX))
          rst_cnt <= rst_cnt + 1'b1;
        else
          rst_cnt <= '0;  // wrap after RST_MAX
      end
    end
  end

  // output register, low during reset and while counting
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      dp_rst_n_o <= 1'b0;
    else
      dp_rst_n_o <= (rst_cnt == '0);
  end

endmodule

// ==== hdl/rp_analog_pkg.sv ====
/*
 * shared widths, counts and sample-pair types of the analog glue
 * everything here runs on adc_clk; no clock domain is implied by a type
 * sample pairs put channel A in the upper half of the packed word
 */

package rp_analog_pkg;

  ////////////////////
  // widths and counts
  ////////////////////

  localparam int ADC_W     = 16;             // raw ADC sample, signed
  localparam int DAC_W     = 14;             // DAC sample and converter code
  localparam int ADC_SHIFT = ADC_W - DAC_W;  // DAC to ADC scale in loopback
  localparam int EXP_W     = 8;              // pins per expansion row

  // data-path reset length after lock
  localparam int RST_MAX   = 64;
  localparam int RST_CNT_W = 7;  // holds RST_MAX

  // code for a zero sample, offset binary with negative slope
  localparam logic [DAC_W-1:0] DAC_ZERO_CODE = 14'h1FFF;

  ////////////////////
  // sample pairs
  ////////////////////

  typedef struct packed {
    logic signed [ADC_W-1:0] cha;  // channel A
    logic signed [ADC_W-1:0] chb;  // channel B
  } adc_pair_t;

  typedef struct packed {
    logic signed [DAC_W-1:0] cha;
    logic signed [DAC_W-1:0] chb;
  } dac_pair_t;

  // converter codes, unsigned
  typedef struct packed {
    logic [DAC_W-1:0] cha;
    logic [DAC_W-1:0] chb;
  } code_pair_t;

  // digital loop select
  typedef struct packed {
    logic adc_loop;  // DAC samples back into the ADC stream
    logic dac_loop;  // raw ADC samples straight to the DAC
  } loop_sel_t;

endpackage

// ==== project.f ====
hdl/rp_analog_pkg.sv
hdl/lock_reset_gen.sv
hdl/adc_stream_sel.sv
hdl/dac_output_stage.sv
hdl/exp_pin_mux.sv
hdl/analog_top.sv
bench/analog_top_assertions.sv
bench/analog_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the analog_top testbench with Verilator
# the result is taken from the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module analog_top_tb \
  -f project.f -o analog_sim \
  && ./obj_dir/analog_sim > sim.log 2>&1 \
  || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log && echo "result: passed" \
  || { echo "result: failed"; exit 1; }
